// File: source/sdio_data_pkg.sv
package sdio_data_pkg;

  // Data path sizes
  localparam int BYTE_W     = 8;
  localparam int ADDR_W     = 18;
  localparam int CNT_W      = 13;
  localparam int BLK_CNT_W  = 10;
  localparam int BLK_SIZE_W = 16;

  // Function targets: CIA at 0, functions 1 to 7, memory last
  localparam int NUM_TARGETS = 9;
  localparam int TGT_IDX_W   = 4;
  localparam int TGT_MEM     = 8;

  // Byte mode count of zero means a full 512 byte transfer
  localparam int BYTE_MODE_DEFAULT_LEN = 512;

  // Block mode view of the data count
  typedef struct packed {
    logic [CNT_W-BLK_CNT_W-1:0] pad;
    logic [BLK_CNT_W-1:0]       blocks;
  } blk_cnt_view_t;

  // One count word, decoded per transfer mode
  typedef union packed {
    logic [CNT_W-1:0] bytes;
    blk_cnt_view_t    blk;
  } data_cnt_u;

  typedef struct packed {
    logic              wr_stb;
    logic [BYTE_W-1:0] wr_data;
    logic              hst_rdy;
    logic              activate;
  } target_out_t;

  typedef struct packed {
    logic                  rd_stb;
    logic [BYTE_W-1:0]     rd_data;
    logic                  com_rdy;
    logic [BLK_SIZE_W-1:0] block_size;
  } target_in_t;

  typedef struct packed {
    logic              stb;
    logic [BYTE_W-1:0] data;
  } phy_wr_t;

  typedef struct packed {
    logic              rd_stb;
    logic [BYTE_W-1:0] rd_data;
    logic              com_rdy;
    logic              activate;
  } phy_rd_t;

  typedef struct packed {
    logic [CNT_W-1:0]     byte_len;
    logic [BLK_CNT_W-1:0] block_total;
    logic                 continuous;
    logic                 block_mode;
  } xfer_cfg_t;

  typedef enum logic [1:0] {
    IDLE,
    CONFIG,
    ACTIVE,
    FINISHED
  } xfer_state_e;

endpackage

// File: source/sdio_xfer_decode.sv
`timescale 1ns/1ps

module sdio_xfer_decode import sdio_data_pkg::*; (
  input  logic                 i_mem_sel,
  input  logic [TGT_IDX_W-1:0] i_func_sel,
  input  logic                 i_block_mode_flg,
  input  data_cnt_u            i_data_cnt,
  input  target_in_t           i_targets [NUM_TARGETS],
  output logic [TGT_IDX_W-1:0] o_tgt_idx,
  output logic                 o_tgt_valid,
  output xfer_cfg_t            o_xfer_cfg
);

  logic [BLK_SIZE_W-1:0] sel_block_size;
  logic                  zero_bytes;

  // Memory select wins over the function number
  always_comb begin
    if (i_mem_sel) begin
      o_tgt_idx   = TGT_IDX_W'(TGT_MEM);
      o_tgt_valid = 1'b1;
    end else begin
      o_tgt_idx   = i_func_sel;
      o_tgt_valid = (i_func_sel < TGT_IDX_W'(TGT_MEM));
    end
  end

  // Block size of the selected target, zero when nothing is selected
  always_comb begin
    sel_block_size = '0;
    for (int i = 0; i < NUM_TARGETS; i++) begin
      if (o_tgt_valid && (o_tgt_idx == TGT_IDX_W'(i))) begin
        sel_block_size = i_targets[i].block_size;
      end
    end
  end

  assign zero_bytes = (i_data_cnt.bytes == '0);

  always_comb begin
    o_xfer_cfg.block_mode = i_block_mode_flg;
    if (i_block_mode_flg) begin
      // Count holds blocks, zero runs until activate drops
      o_xfer_cfg.block_total = i_data_cnt.blk.blocks;
      o_xfer_cfg.continuous  = (i_data_cnt.blk.blocks == '0);
      o_xfer_cfg.byte_len    = sel_block_size[CNT_W-1:0];
    end else begin
      o_xfer_cfg.block_total = '0;
      o_xfer_cfg.continuous  = 1'b0;
      if (zero_bytes) begin
        o_xfer_cfg.byte_len = CNT_W'(BYTE_MODE_DEFAULT_LEN);
      end else begin
        o_xfer_cfg.byte_len = i_data_cnt.bytes;
      end
    end
  end

endmodule

// File: source/sdio_xfer_engine.sv
`timescale 1ns/1ps

module sdio_xfer_engine import sdio_data_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_activate,
  input  logic              i_inc_addr_flg,
  input  logic [ADDR_W-1:0] i_cmd_address,
  input  xfer_cfg_t         i_xfer_cfg,
  input  logic              i_byte_stb,
  output logic              o_hst_rdy,
  output logic [ADDR_W-1:0] o_address,
  output logic [CNT_W-1:0]  o_total_data_cnt,
  output logic              o_finished
);

  xfer_state_e          state;
  logic [CNT_W-1:0]     byte_cnt;
  logic [BLK_CNT_W-1:0] blk_cnt;
  logic                 room;
  logic                 byte_acc;
  logic                 more_blocks;

  // Bytes past the block length are dropped
  assign room     = (byte_cnt < o_total_data_cnt);
  assign byte_acc = o_hst_rdy && i_byte_stb && room;

  assign more_blocks = i_xfer_cfg.continuous || (blk_cnt < i_xfer_cfg.block_total);

  always_ff @(posedge clk) begin
    if (rst) begin
      state            <= IDLE;
      o_hst_rdy        <= 1'b0;
      o_finished       <= 1'b0;
      o_address        <= '0;
      o_total_data_cnt <= '0;
      byte_cnt         <= '0;
      blk_cnt          <= '0;
    end else begin
      case (state)
        IDLE: begin
          o_hst_rdy        <= 1'b0;
          o_finished       <= 1'b0;
          o_total_data_cnt <= '0;
          byte_cnt         <= '0;
          blk_cnt          <= '0;
          o_address        <= i_cmd_address;
          if (i_activate) begin
            state <= CONFIG;
          end
        end

        CONFIG: begin
          // Load the length of the next block or of the byte transfer
          byte_cnt         <= '0;
          o_total_data_cnt <= i_xfer_cfg.byte_len;
          if (!i_xfer_cfg.continuous) begin
            blk_cnt <= blk_cnt + 1'b1;
          end
          state <= ACTIVE;
        end

        ACTIVE: begin
          if (room) begin
            o_hst_rdy <= 1'b1;
            if (byte_acc) begin
              byte_cnt <= byte_cnt + 1'b1;
              if (i_inc_addr_flg) begin
                o_address <= o_address + 1'b1;
              end
            end
          end else begin
            // Block done, close the window before the next one
            o_hst_rdy <= 1'b0;
            if (more_blocks) begin
              state <= CONFIG;
            end else begin
              state <= FINISHED;
            end
          end
        end

        FINISHED: begin
          o_finished <= 1'b1;
        end

        default: begin
          state <= IDLE;
        end
      endcase

      // Host drops activate to end or abort the transfer
      if (!i_activate) begin
        state <= IDLE;
      end
    end
  end

  a_cnt_bound: assert property (
    @(posedge clk) disable iff (rst)
    (state == ACTIVE) |=> (byte_cnt <= o_total_data_cnt)
  ) else $error("byte counter ran past the transfer length");

  a_fin_quiet: assert property (
    @(posedge clk) disable iff (rst)
    o_finished |-> !o_hst_rdy
  ) else $error("finished flag raised while still accepting bytes");

endmodule

// File: source/sdio_target_router.sv
`timescale 1ns/1ps

module sdio_target_router import sdio_data_pkg::*; (
  input  logic [TGT_IDX_W-1:0] i_tgt_idx,
  input  logic                 i_tgt_valid,
  input  logic                 i_activate,
  input  logic                 i_hst_rdy,
  input  phy_wr_t              i_phy_wr,
  input  target_in_t           i_targets [NUM_TARGETS],
  output target_out_t          o_targets [NUM_TARGETS],
  output phy_rd_t              o_phy_rd,
  output logic                 o_byte_stb
);

  target_in_t             sel_in;
  logic [NUM_TARGETS-1:0] act_vec;

  // PHY writes and control levels reach only the selected target
  always_comb begin
    sel_in = '0;
    for (int i = 0; i < NUM_TARGETS; i++) begin
      o_targets[i] = '0;
      if (i_tgt_valid && (i_tgt_idx == TGT_IDX_W'(i))) begin
        o_targets[i].wr_stb   = i_phy_wr.stb;
        o_targets[i].wr_data  = i_phy_wr.data;
        o_targets[i].hst_rdy  = i_hst_rdy;
        o_targets[i].activate = i_activate;
        sel_in                = i_targets[i];
      end
    end
  end

  // Read path back to the PHY
  always_comb begin
    o_phy_rd.activate = i_activate;
    o_phy_rd.rd_stb   = sel_in.rd_stb;
    o_phy_rd.rd_data  = sel_in.rd_data;
    // Target can only accept or offer data while the engine is open
    o_phy_rd.com_rdy  = sel_in.com_rdy & i_hst_rdy;
  end

  // Only strobes of a valid target are reported
  assign o_byte_stb = i_tgt_valid && (i_phy_wr.stb || sel_in.rd_stb);

  always_comb begin
    for (int i = 0; i < NUM_TARGETS; i++) begin
      act_vec[i] = o_targets[i].activate;
    end
  end

  // At most one target owns the transfer
  always_comb begin
    a_one_owner: assert ($onehot0(act_vec))
      else $error("more than one target activated");
  end

endmodule

// File: source/sdio_data_control.sv
`timescale 1ns/1ps

module sdio_data_control import sdio_data_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 i_activate,
  input  logic                 i_write_flg,
  input  logic                 i_block_mode_flg,
  input  logic                 i_inc_addr_flg,
  input  logic                 i_mem_sel,
  input  logic [TGT_IDX_W-1:0] i_func_sel,
  input  data_cnt_u            i_data_cnt,
  input  logic [ADDR_W-1:0]    i_cmd_address,
  input  phy_wr_t              i_phy_wr,
  input  target_in_t           i_targets [NUM_TARGETS],
  output phy_rd_t              o_phy_rd,
  output target_out_t          o_targets [NUM_TARGETS],
  output logic [ADDR_W-1:0]    o_address,
  output logic [CNT_W-1:0]     o_total_data_cnt,
  output logic                 o_finished
);

  logic [TGT_IDX_W-1:0] tgt_idx;
  logic                 tgt_valid;
  xfer_cfg_t            xfer_cfg;
  logic                 hst_rdy;
  logic                 byte_stb;

  sdio_xfer_decode u_decode (
    .i_mem_sel        (i_mem_sel),
    .i_func_sel       (i_func_sel),
    .i_block_mode_flg (i_block_mode_flg),
    .i_data_cnt       (i_data_cnt),
    .i_targets        (i_targets),
    .o_tgt_idx        (tgt_idx),
    .o_tgt_valid      (tgt_valid),
    .o_xfer_cfg       (xfer_cfg)
  );

  sdio_xfer_engine u_engine (
    .clk              (clk),
    .rst              (rst),
    .i_activate       (i_activate),
    .i_inc_addr_flg   (i_inc_addr_flg),
    .i_cmd_address    (i_cmd_address),
    .i_xfer_cfg       (xfer_cfg),
    .i_byte_stb       (byte_stb),
    .o_hst_rdy        (hst_rdy),
    .o_address        (o_address),
    .o_total_data_cnt (o_total_data_cnt),
    .o_finished       (o_finished)
  );

  sdio_target_router u_router (
    .i_tgt_idx   (tgt_idx),
    .i_tgt_valid (tgt_valid),
    .i_activate  (i_activate),
    .i_hst_rdy   (hst_rdy),
    .i_phy_wr    (i_phy_wr),
    .i_targets   (i_targets),
    .o_targets   (o_targets),
    .o_phy_rd    (o_phy_rd),
    .o_byte_stb  (byte_stb)
  );

  // Write transfers never send target read bytes out to the PHY
  a_write_dir: assert property (
    @(posedge clk) disable iff (rst)
    (i_activate && i_write_flg) |-> !o_phy_rd.rd_stb
  ) else $error("read strobe reached the PHY during a write");

endmodule

// File: test/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic o_clk,
  output logic o_rst
);

  initial begin
    o_clk = 1'b0;
    forever #5 o_clk = ~o_clk;
  end

  // Reset held over the first three rising edges
  initial begin
    o_rst = 1'b1;
    repeat (3) @(posedge o_clk);
    o_rst <= 1'b0;
  end

endmodule

// File: test/tb_sdio_data_control.sv
`timescale 1ns/1ps

module tb_sdio_data_control import sdio_data_pkg::*;;

  localparam int XFER_BYTES    = 5 + 4 + 512 + 12 + 3;
  localparam int TEST_OVERHEAD = 30;
  localparam int CYCLE_LIMIT   = (XFER_BYTES + 5 * TEST_OVERHEAD) * 2;

  logic                 clk;
  logic                 rst;
  logic                 i_activate;
  logic                 i_write_flg;
  logic                 i_block_mode_flg;
  logic                 i_inc_addr_flg;
  logic                 i_mem_sel;
  logic [TGT_IDX_W-1:0] i_func_sel;
  data_cnt_u            i_data_cnt;
  logic [ADDR_W-1:0]    i_cmd_address;
  phy_wr_t              i_phy_wr;
  target_in_t           i_targets [NUM_TARGETS];
  phy_rd_t              o_phy_rd;
  target_out_t          o_targets [NUM_TARGETS];
  logic [ADDR_W-1:0]    o_address;
  logic [CNT_W-1:0]     o_total_data_cnt;
  logic                 o_finished;
  int                   seed;
  int                   checks = 0;
  int                   errs = 0;
  int                   cycles = 0;

  tb_clock_gen u_clk_gen (.o_clk(clk), .o_rst(rst));

  sdio_data_control dut (.*);

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      $display("Timeout: tests still running after %0d cycles", cycles);
      $display("Verification failed");
      $finish;
    end
  end

  task automatic check_byte(input logic [BYTE_W-1:0] got, exp, input string what);
    checks++;
    if (got !== exp) begin
      errs++;
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input logic [ADDR_W-1:0] got, exp, input string what);
    checks++;
    if (got !== exp) begin
      errs++;
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_cnt(input logic [CNT_W-1:0] got, exp, input string what);
    checks++;
    if (got !== exp) begin
      errs++;
      $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, exp, input string what);
    checks++;
    if (got !== exp) begin
      errs++;
      $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Unselected targets must see all zeros
  // A skip of -1 checks all nine
  task automatic others_quiet(input int skip);
    for (int j = 0; j < NUM_TARGETS; j++) begin
      if (j != skip) begin
        check_flag(o_targets[j] != '0, 1'b0, $sformatf("target %0d output busy", j));
      end
    end
  endtask

  task automatic open_xfer(input logic wr, blk, inc, mem, input logic [TGT_IDX_W-1:0] fsel,
                           input logic [CNT_W-1:0] cnt, input logic [ADDR_W-1:0] addr);
    @(posedge clk);
    i_write_flg      <= wr;
    i_block_mode_flg <= blk;
    i_inc_addr_flg   <= inc;
    i_mem_sel        <= mem;
    i_func_sel       <= fsel;
    i_data_cnt.bytes <= cnt;
    i_cmd_address    <= addr;
    i_activate       <= 1'b1;
  endtask

  // PHY and target model in one
  // A byte moves when com_rdy is high in its cycle
  task automatic move_bytes(input int tgt, input logic wr, input int n, input int blk_len);
    int                done;
    int                in_blk;
    logic [BYTE_W-1:0] b;
    done   = 0;
    in_blk = 0;
    b      = BYTE_W'($random(seed));
    while (done < n) begin
      @(posedge clk);
      if (wr) begin
        i_phy_wr.stb  <= (in_blk < blk_len);
        i_phy_wr.data <= b;
      end else begin
        i_targets[tgt].rd_stb  <= (in_blk < blk_len);
        i_targets[tgt].rd_data <= b;
      end
      @(negedge clk);
      check_flag(o_finished, 1'b0, "finished before last byte");
      check_flag(o_phy_rd.activate, 1'b1, "PHY activate");
      check_flag(o_targets[tgt].activate, 1'b1, "target activate");
      others_quiet(tgt);
      if (!o_phy_rd.com_rdy) begin
        // Window closed between blocks
        check_flag(o_targets[tgt].hst_rdy, 1'b0, "target hst_rdy while closed");
        in_blk = 0;
      end else if (in_blk < blk_len) begin
        check_flag(o_targets[tgt].hst_rdy, 1'b1, "target hst_rdy");
        check_flag(wr ? o_targets[tgt].wr_stb : o_phy_rd.rd_stb, 1'b1, "routed strobe");
        check_byte(wr ? o_targets[tgt].wr_data : o_phy_rd.rd_data, b, "routed data");
        done++;
        in_blk++;
        b = BYTE_W'($random(seed));
      end
    end
    @(posedge clk);
    i_phy_wr.stb           <= 1'b0;
    i_targets[tgt].rd_stb  <= 1'b0;
  endtask

  task automatic wait_finished();
    do @(negedge clk); while (!o_finished);
  endtask

  task automatic close_xfer();
    @(posedge clk);
    i_activate <= 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
  endtask

  task automatic byte_write_func3();
    open_xfer(1'b1, 1'b0, 1'b1, 1'b0, 4'd3, 13'd5, 18'h00100);
    move_bytes(3, 1'b1, 5, 5);
    wait_finished();
    check_cnt(o_total_data_cnt, 13'd5, "byte mode length");
    check_addr(o_address, 18'h00105, "address after five bytes");
    close_xfer();
  endtask

  task automatic mem_read_no_inc();
    // Memory select overrides function 2
    open_xfer(1'b0, 1'b0, 1'b0, 1'b1, 4'd2, 13'd4, 18'h002a0);
    move_bytes(TGT_MEM, 1'b0, 4, 4);
    wait_finished();
    check_cnt(o_total_data_cnt, 13'd4, "memory read length");
    check_addr(o_address, 18'h002a0, "address without increment");
    close_xfer();
  endtask

  task automatic zero_count_default();
    open_xfer(1'b1, 1'b0, 1'b1, 1'b0, 4'd1, 13'd0, 18'h00000);
    move_bytes(1, 1'b1, 512, 512);
    wait_finished();
    check_cnt(o_total_data_cnt, 13'd512, "zero count length");
    check_addr(o_address, 18'h00200, "address after 512 bytes");
    close_xfer();
  endtask

  task automatic block_write_three();
    open_xfer(1'b1, 1'b1, 1'b1, 1'b0, 4'd5, 13'd3, 18'h01000);
    move_bytes(5, 1'b1, 12, 4);
    wait_finished();
    check_cnt(o_total_data_cnt, 13'd4, "block length");
    check_addr(o_address, 18'h0100c, "address after three blocks");
    close_xfer();
  endtask

  task automatic bad_func_then_abort();
    open_xfer(1'b0, 1'b0, 1'b1, 1'b0, 4'd9, 13'd6, 18'h00040);
    i_phy_wr.stb          <= 1'b1;
    i_targets[1].rd_stb   <= 1'b1;
    i_targets[1].rd_data  <= 8'ha5;
    // Long enough for six counted strobes to finish a transfer
    repeat (12) begin
      @(negedge clk);
      others_quiet(-1);
      check_flag(o_phy_rd.activate, 1'b1, "PHY activate without target");
      check_flag(o_phy_rd.com_rdy, 1'b0, "com_rdy without target");
      check_byte(o_phy_rd.rd_data, 8'h00, "read data without target");
      check_flag(o_finished, 1'b0, "finished without target");
    end
    check_addr(o_address, 18'h00040, "address without target");
    @(posedge clk);
    i_phy_wr.stb        <= 1'b0;
    i_targets[1].rd_stb <= 1'b0;
    close_xfer();
    // Abort after three of eight bytes
    open_xfer(1'b1, 1'b0, 1'b1, 1'b0, 4'd4, 13'd8, 18'h00040);
    move_bytes(4, 1'b1, 3, 8);
    close_xfer();
    check_flag(o_finished, 1'b0, "finished after abort");
    check_flag(o_phy_rd.com_rdy, 1'b0, "com_rdy after abort");
    check_flag(o_phy_rd.activate, 1'b0, "PHY activate after abort");
    check_addr(o_address, 18'h00040, "address reloaded in idle");
  endtask

  initial begin
    seed             = 24;
    i_activate       = 1'b0;
    i_write_flg      = 1'b0;
    i_block_mode_flg = 1'b0;
    i_inc_addr_flg   = 1'b0;
    i_mem_sel        = 1'b0;
    i_func_sel       = '0;
    i_data_cnt       = '0;
    i_cmd_address    = '0;
    i_phy_wr         = '0;
    for (int i = 0; i < NUM_TARGETS; i++) begin
      i_targets[i]            = '0;
      i_targets[i].com_rdy    = 1'b1;
      i_targets[i].block_size = (i == 5) ? 16'd4 : BLK_SIZE_W'(32 + i);
    end
    @(negedge rst);
    byte_write_func3();
    mem_read_no_inc();
    zero_count_default();
    block_write_three();
    bad_func_then_abort();
    $display("Checks run: %0d, errors: %0d", checks, errs);
    if (errs == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: sdio_data_control.f
source/sdio_data_pkg.sv
source/sdio_xfer_decode.sv
source/sdio_xfer_engine.sv
source/sdio_target_router.sv
source/sdio_data_control.sv
test/tb_clock_gen.sv
test/tb_sdio_data_control.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the SDIO data control testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_sdio_data_control \
  -f sdio_data_control.f \
  --Mdir obj_dir -o sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^Verification passed$" sim.log; then
  exit 0
else
  exit 1
fi
